// File: rtl/cluster_cfg_pkg.sv
// ##############################
// Fixed field widths of the compute cluster
// and the vector types built on them
// ##############################

`default_nettype none

package cluster_cfg_pkg;

    // Program counter width
    localparam int unsigned PcWidth = 16;

    // Unique thread-group id width
    localparam int unsigned TgroupIdBits = 8;

    // Block index inside a thread group
    localparam int unsigned TblockIdxBits = 8;

    // Low index bits that set how long a block runs
    localparam int unsigned RunLenBits = 4;

    typedef logic [PcWidth-1:0] pc_t;
    typedef logic [TgroupIdBits-1:0] tgroup_id_t;
    typedef logic [TblockIdxBits-1:0] tblock_idx_t;

    // One extra bit so that 16 cycles fits, range is 1 to 16
    typedef logic [RunLenBits:0] run_len_t;

endpackage

`default_nettype wire

// File: rtl/tblock_pkg.sv
// ##############################
// Allocation and completion records
// and the warp slot state encoding
// ##############################

`default_nettype none

package tblock_pkg;

    // Thread block handed to the cluster, 32 bits
    typedef struct packed {
        cluster_cfg_pkg::pc_t         pc;
        cluster_cfg_pkg::tblock_idx_t tblock_idx;
        cluster_cfg_pkg::tgroup_id_t  tgroup_id;
    } alloc_t;

    // Completion of one thread block, 24 bits
    typedef struct packed {
        cluster_cfg_pkg::tgroup_id_t tgroup_id;
        cluster_cfg_pkg::pc_t        end_pc;
    } done_t;

    // ##############################
    // Warp slot life cycle
    // FREE -> RUN on allocation
    // RUN -> DONE when the countdown expires
    // DONE -> FREE when the completion is taken
    typedef enum logic [1:0] {
        WARP_FREE = 2'd0,
        WARP_RUN  = 2'd1,
        WARP_DONE = 2'd2
    } warp_state_e;

endpackage

`default_nettype wire

// File: rtl/tblock_dispatch.sv
// ##############################
// Thread block dispatcher with one
// holding register per compute unit
// ##############################

`timescale 1ns/1ps
`default_nettype none

module tblock_dispatch #(
    parameter int unsigned ComputeUnits = 2
) (
    input  wire logic clk_i,
    input  wire logic rst_n_i,

    // Allocation from outside the cluster
    input  wire logic                 alloc_valid_i,
    input  wire tblock_pkg::alloc_t   alloc_data_i,
    output logic                      alloc_ready_o,

    // One handshake per compute unit
    input  wire logic [ComputeUnits-1:0]                cu_warp_free_i,
    output logic [ComputeUnits-1:0]                     cu_alloc_valid_o,
    output tblock_pkg::alloc_t [ComputeUnits-1:0]       cu_alloc_data_o
);

    logic [ComputeUnits-1:0] hold_valid_q;
    tblock_pkg::alloc_t [ComputeUnits-1:0] hold_data_q;

    logic [ComputeUnits-1:0] sel;
    logic [ComputeUnits-1:0] load;
    logic [ComputeUnits-1:0] take;

    // ##############################
    // Unit selection

    // Lowest unit whose holding register is empty
    always_comb begin
        sel = '0;
        for (int k = 0; k < ComputeUnits; k++) begin
            if (!hold_valid_q[k] && (sel == '0)) begin
                sel[k] = 1'b1;
            end
        end
    end

    // Ready only looks at the holding registers, never at the valid
    assign alloc_ready_o = ~&hold_valid_q;

    assign load = alloc_valid_i ? sel : '0;

    // A unit takes its record when it shows a free slot
    assign take = hold_valid_q & cu_warp_free_i;

    // ##############################
    // Holding registers

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hold_valid_q <= '0;
        end else begin
            hold_valid_q <= (hold_valid_q & ~take) | load;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int k = 0; k < ComputeUnits; k++) begin
            if (load[k]) begin
                hold_data_q[k] <= alloc_data_i;
            end
        end
    end

    assign cu_alloc_valid_o = hold_valid_q;
    assign cu_alloc_data_o  = hold_data_q;

    // Only one unit may receive a block per cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(load) && ((load & hold_valid_q) == '0))
    else $error("dispatch loaded more than one or a full holding register");

endmodule

`default_nettype wire

// File: rtl/compute_unit.sv
// ##############################
// Compute unit with warp slots that
// count down each block's run length
// ##############################

`timescale 1ns/1ps
`default_nettype none

module compute_unit #(
    parameter int unsigned NumWarps = 4
) (
    input  wire logic clk_i,
    input  wire logic rst_n_i,

    // Block allocation from the dispatcher
    input  wire logic               alloc_valid_i,
    input  wire tblock_pkg::alloc_t alloc_data_i,
    output logic                    warp_free_o,

    // Completion towards the arbiter
    input  wire logic               done_ready_i,
    output logic                    done_valid_o,
    output tblock_pkg::done_t       done_data_o
);

    localparam int unsigned SlotIdxW = (NumWarps > 1) ? $clog2(NumWarps) : 1;

    typedef logic [SlotIdxW-1:0] slot_idx_t;

    // Per slot state, countdown and completion record
    tblock_pkg::warp_state_e [NumWarps-1:0] state_q;
    cluster_cfg_pkg::run_len_t [NumWarps-1:0] cnt_q;
    tblock_pkg::done_t [NumWarps-1:0] rec_q;

    logic free_any;
    logic done_any;
    slot_idx_t free_idx;
    slot_idx_t done_idx;

    logic alloc_take;
    logic done_take;
    cluster_cfg_pkg::run_len_t run_len;

    // ##############################
    // Slot search, lowest index wins
    always_comb begin
        free_any = 1'b0;
        free_idx = '0;
        done_any = 1'b0;
        done_idx = '0;
        for (int w = NumWarps - 1; w >= 0; w--) begin
            if (state_q[w] == tblock_pkg::WARP_FREE) begin
                free_any = 1'b1;
                free_idx = slot_idx_t'(w);
            end
            if (state_q[w] == tblock_pkg::WARP_DONE) begin
                done_any = 1'b1;
                done_idx = slot_idx_t'(w);
            end
        end
    end

    assign warp_free_o  = free_any;
    assign alloc_take   = alloc_valid_i && free_any;

    assign done_valid_o = done_any;
    assign done_data_o  = rec_q[done_idx];
    assign done_take    = done_any && done_ready_i;

    // Run length is the low index bits plus one
    assign run_len = cluster_cfg_pkg::run_len_t'(
        alloc_data_i.tblock_idx[cluster_cfg_pkg::RunLenBits-1:0]) + 1'b1;

    // ##############################
    // Slot state and countdown
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < NumWarps; w++) begin
                state_q[w] <= tblock_pkg::WARP_FREE;
            end
            cnt_q <= '0;
        end else begin
            for (int w = 0; w < NumWarps; w++) begin
                case (state_q[w])
                    tblock_pkg::WARP_FREE: begin
                        if (alloc_take && (free_idx == slot_idx_t'(w))) begin
                            state_q[w] <= tblock_pkg::WARP_RUN;
                            cnt_q[w]   <= run_len;
                        end
                    end
                    tblock_pkg::WARP_RUN: begin
                        // Last running cycle, hand over to done
                        if (cnt_q[w] == cluster_cfg_pkg::run_len_t'(1)) begin
                            state_q[w] <= tblock_pkg::WARP_DONE;
                        end
                        cnt_q[w] <= cnt_q[w] - 1'b1;
                    end
                    tblock_pkg::WARP_DONE: begin
                        if (done_take && (done_idx == slot_idx_t'(w))) begin
                            state_q[w] <= tblock_pkg::WARP_FREE;
                        end
                    end
                    default: state_q[w] <= tblock_pkg::WARP_FREE;
                endcase
            end
        end
    end

    // Completion record is built when the block lands
    always_ff @(posedge clk_i) begin
        if (alloc_take) begin
            rec_q[free_idx].tgroup_id <= alloc_data_i.tgroup_id;
            rec_q[free_idx].end_pc    <= alloc_data_i.pc + cluster_cfg_pkg::pc_t'(run_len);
        end
    end

    // A block may only land in a slot that is really free
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alloc_take |-> (state_q[free_idx] == tblock_pkg::WARP_FREE))
    else $error("allocation landed in a slot that is not free");

    for (genvar w = 0; w < NumWarps; w++) begin : gen_slot_checks
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            (state_q[w] == tblock_pkg::WARP_RUN) |-> (cnt_q[w] != '0))
        else $error("running slot with an expired counter");
    end

endmodule

`default_nettype wire

// File: rtl/tblock_done_arbiter.sv
// ##############################
// Round-robin completion arbiter
// and the registered cluster output
// ##############################

`timescale 1ns/1ps
`default_nettype none

module tblock_done_arbiter #(
    parameter int unsigned ComputeUnits = 2
) (
    input  wire logic clk_i,
    input  wire logic rst_n_i,

    // Completions offered by the units
    input  wire logic [ComputeUnits-1:0]              cu_done_valid_i,
    input  wire tblock_pkg::done_t [ComputeUnits-1:0] cu_done_data_i,
    output logic [ComputeUnits-1:0]                   cu_done_ready_o,

    // Registered completion stream
    input  wire logic         out_ready_i,
    output logic              out_valid_o,
    output tblock_pkg::done_t out_data_o
);

    localparam int unsigned CuIdxW = (ComputeUnits > 1) ? $clog2(ComputeUnits) : 1;

    typedef logic [CuIdxW-1:0] cu_idx_t;

    cu_idx_t last_q;
    cu_idx_t gnt_idx;
    logic gnt_any;
    logic [ComputeUnits-1:0] gnt_mask;

    logic in_ready;
    logic in_take;

    logic out_valid_q;
    tblock_pkg::done_t out_data_q;

    // ##############################
    // Round-robin grant, search starts after the last winner
    always_comb begin
        int unsigned cand;
        gnt_any  = 1'b0;
        gnt_idx  = last_q;
        gnt_mask = '0;
        for (int unsigned i = 1; i <= ComputeUnits; i++) begin
            cand = (int'(last_q) + i) % ComputeUnits;
            if (!gnt_any && cu_done_valid_i[cand]) begin
                gnt_any = 1'b1;
                gnt_idx = cu_idx_t'(cand);
            end
        end
        if (gnt_any) begin
            gnt_mask[gnt_idx] = 1'b1;
        end
    end

    // Output register accepts when empty or draining this cycle
    assign in_ready = !out_valid_q || out_ready_i;
    assign in_take  = gnt_any && in_ready;

    assign cu_done_ready_o = in_ready ? gnt_mask : '0;

    // ##############################
    // Pointer and output register
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_q      <= cu_idx_t'(ComputeUnits - 1);
            out_valid_q <= 1'b0;
        end else begin
            if (in_take) begin
                last_q      <= gnt_idx;
                out_valid_q <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_take) begin
            out_data_q <= cu_done_data_i[gnt_idx];
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_data_o  = out_data_q;

    // Grant goes to a single unit that actually offers something
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(cu_done_ready_o) && ((cu_done_ready_o & ~cu_done_valid_i) == '0))
    else $error("completion grant not one-hot");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)))
    else $error("held completion changed before it was accepted");

endmodule

`default_nettype wire

// File: rtl/compute_cluster.sv
// ##############################
// Compute cluster top level
// ##############################

`timescale 1ns/1ps
`default_nettype none

module compute_cluster #(
    parameter int unsigned ComputeUnits = 2,
    parameter int unsigned NumWarps     = 4
) (
    input  wire logic clk_i,
    input  wire logic rst_n_i,

    // New thread blocks
    input  wire logic               allocate_warp_i,
    input  wire tblock_pkg::alloc_t allocate_data_i,
    output logic                    warp_free_o,

    // Thread block completion
    input  wire logic               tblock_done_ready_i,
    output logic                    tblock_done_o,
    output tblock_pkg::done_t       tblock_done_data_o
);

    // Dispatcher to units
    logic [ComputeUnits-1:0] cu_alloc_valid;
    tblock_pkg::alloc_t [ComputeUnits-1:0] cu_alloc_data;
    logic [ComputeUnits-1:0] cu_warp_free;

    // Units to arbiter
    logic [ComputeUnits-1:0] cu_done_valid;
    tblock_pkg::done_t [ComputeUnits-1:0] cu_done_data;
    logic [ComputeUnits-1:0] cu_done_ready;

    tblock_dispatch #(
        .ComputeUnits ( ComputeUnits )
    ) i_dispatch (
        .clk_i            ( clk_i           ),
        .rst_n_i          ( rst_n_i         ),
        .alloc_valid_i    ( allocate_warp_i ),
        .alloc_data_i     ( allocate_data_i ),
        .alloc_ready_o    ( warp_free_o     ),
        .cu_warp_free_i   ( cu_warp_free    ),
        .cu_alloc_valid_o ( cu_alloc_valid  ),
        .cu_alloc_data_o  ( cu_alloc_data   )
    );

    for (genvar cu = 0; cu < ComputeUnits; cu++) begin : gen_compute_units
        compute_unit #(
            .NumWarps ( NumWarps )
        ) i_cu (
            .clk_i         ( clk_i              ),
            .rst_n_i       ( rst_n_i            ),
            .alloc_valid_i ( cu_alloc_valid[cu] ),
            .alloc_data_i  ( cu_alloc_data[cu]  ),
            .warp_free_o   ( cu_warp_free[cu]   ),
            .done_ready_i  ( cu_done_ready[cu]  ),
            .done_valid_o  ( cu_done_valid[cu]  ),
            .done_data_o   ( cu_done_data[cu]   )
        );
    end

    tblock_done_arbiter #(
        .ComputeUnits ( ComputeUnits )
    ) i_done_arbiter (
        .clk_i           ( clk_i               ),
        .rst_n_i         ( rst_n_i             ),
        .cu_done_valid_i ( cu_done_valid       ),
        .cu_done_data_i  ( cu_done_data        ),
        .cu_done_ready_o ( cu_done_ready       ),
        .out_ready_i     ( tblock_done_ready_i ),
        .out_valid_o     ( tblock_done_o       ),
        .out_data_o      ( tblock_done_data_o  )
    );

endmodule

`default_nettype wire

// File: tb/tb_tasks.svh
// ##############################
// Compare, scoreboard, drive, wait
// and directed test tasks
// ##############################

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ##############################
// Compare

task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
        value_errors++;
        $display("FAILED time=%0t %s: got %b expected %b", $time, name, got, want);
    end
endtask

task automatic check_done(input string name, input tblock_pkg::done_t got,
                          input tblock_pkg::done_t want);
    if (got !== want) begin
        value_errors++;
        $display("FAILED time=%0t %s: got gid %h end_pc %h expected gid %h end_pc %h",
                 $time, name, got.tgroup_id, got.end_pc, want.tgroup_id, want.end_pc);
    end
endtask

task automatic report_error(input string what);
    other_errors++;
    $display("ERROR time=%0t %s", $time, what);
endtask

// ##############################
// Scoreboard

// Run length is the low four index bits plus one
task automatic expect_done(input tblock_pkg::alloc_t blk);
    tblock_pkg::done_t want;
    want.tgroup_id = blk.tgroup_id;
    want.end_pc    = blk.pc + cluster_cfg_pkg::pc_t'(blk.tblock_idx[3:0]) + 16'd1;
    if (exp_vld[blk.tgroup_id]) begin
        report_error($sformatf("group id %h allocated while still outstanding",
                               blk.tgroup_id));
    end
    exp_done[blk.tgroup_id] = want;
    exp_vld[blk.tgroup_id]  = 1'b1;
    outstanding++;
endtask

task automatic record_completion(input tblock_pkg::done_t got);
    received++;
    last_done = got;
    if (!exp_vld[got.tgroup_id]) begin
        report_error($sformatf("completion for unknown group id %h", got.tgroup_id));
    end else begin
        check_done("tblock_done_data_o", got, exp_done[got.tgroup_id]);
        exp_vld[got.tgroup_id] = 1'b0;
        outstanding--;
    end
endtask

// ##############################
// Drive and wait, all start and end 2 ns after a rising edge

task automatic send_block(input tblock_pkg::alloc_t blk, input int limit,
                          output logic accepted);
    int cycles;
    accepted = 1'b0;
    cycles = 0;
    allocate_warp_i = 1'b1;
    allocate_data_i = blk;
    while (!accepted && cycles < limit) begin
        @(negedge clk_i);
        // Transfer happens on the coming edge
        if (warp_free_o) begin
            accepted = 1'b1;
            expect_done(blk);
        end
        @(posedge clk_i);
        #2;
        cycles++;
    end
    allocate_warp_i = 1'b0;
endtask

task automatic idle_cycles(input int n);
    repeat (n) begin
        @(posedge clk_i);
        #2;
    end
endtask

task automatic wait_until_drained(input int limit);
    int cycles;
    cycles = 0;
    while (outstanding != 0 && cycles < limit) begin
        @(posedge clk_i);
        #2;
        cycles++;
    end
    if (outstanding != 0) begin
        report_error($sformatf("%0d completions missing after %0d cycles",
                               outstanding, limit));
    end
endtask

task automatic wait_for_warp_free(input int limit);
    int cycles;
    cycles = 0;
    while (!warp_free_o && cycles < limit) begin
        @(posedge clk_i);
        #2;
        cycles++;
    end
    if (!warp_free_o) begin
        report_error($sformatf("warp_free_o still low after %0d cycles", limit));
    end
endtask

// ##############################
// Directed tests

task automatic test_after_reset();
    check_flag("warp_free_o", warp_free_o, 1'b1);
    check_flag("tblock_done_o", tblock_done_o, 1'b0);
    repeat (50) begin
        @(negedge clk_i);
        check_flag("tblock_done_o", tblock_done_o, 1'b0);
    end
    @(posedge clk_i);
    #2;
endtask

task automatic test_single_block();
    tblock_pkg::alloc_t blk;
    tblock_pkg::done_t want;
    logic accepted;
    blk.pc = 16'h0100;
    blk.tblock_idx = 8'h07;
    blk.tgroup_id = 8'h01;
    want.tgroup_id = 8'h01;
    want.end_pc = 16'h0108;
    tblock_done_ready_i = 1'b1;
    send_block(blk, 20, accepted);
    if (!accepted) begin
        report_error("single block was not accepted");
    end
    wait_until_drained(100);
    check_done("tblock_done_data_o", last_done, want);
endtask

task automatic test_backpressure();
    tblock_pkg::alloc_t blk;
    logic accepted;
    int n;
    tblock_done_ready_i = 1'b0;
    accepted = 1'b1;
    n = 0;
    while (accepted && n < 2 * Capacity) begin
        blk.pc = 16'h2000 + cluster_cfg_pkg::pc_t'(n * 16);
        blk.tblock_idx = cluster_cfg_pkg::tblock_idx_t'(n);
        blk.tgroup_id = 8'h10 + cluster_cfg_pkg::tgroup_id_t'(n);
        // 40 cycles is well past the longest run length
        send_block(blk, 40, accepted);
        if (accepted) begin
            n++;
        end
    end
    if (n != Capacity) begin
        report_error($sformatf("%0d blocks accepted under back-pressure, expected %0d",
                               n, Capacity));
    end
    check_flag("warp_free_o", warp_free_o, 1'b0);
    check_flag("tblock_done_o", tblock_done_o, 1'b1);
endtask

task automatic test_drain();
    int first;
    first = received;
    tblock_done_ready_i = 1'b1;
    wait_until_drained(400);
    if (received - first != Capacity) begin
        report_error($sformatf("%0d completions drained, expected %0d",
                               received - first, Capacity));
    end
    wait_for_warp_free(50);
    check_flag("warp_free_o", warp_free_o, 1'b1);
endtask

task automatic test_random_traffic();
    tblock_pkg::alloc_t blk;
    logic accepted;
    int first;
    first = received;
    ready_random = 1'b1;
    for (int i = 0; i < 60; i++) begin
        blk.pc = cluster_cfg_pkg::pc_t'($urandom);
        blk.tblock_idx = cluster_cfg_pkg::tblock_idx_t'($urandom);
        blk.tgroup_id = 8'h40 + cluster_cfg_pkg::tgroup_id_t'(i);
        send_block(blk, 200, accepted);
        if (!accepted) begin
            report_error($sformatf("random block %0d was not accepted", i));
        end
        idle_cycles($urandom_range(3, 0));
    end
    ready_random = 1'b0;
    idle_cycles(1);
    tblock_done_ready_i = 1'b1;
    wait_until_drained(500);
    if (received - first != 60) begin
        report_error($sformatf("%0d random completions received, expected 60",
                               received - first));
    end
endtask

`endif

// File: tb/tb_compute_cluster.sv
// ##############################
// Compute cluster testbench with clock, reset,
// scoreboard storage and the completion monitor
// ##############################

`timescale 1ns/1ps
`default_nettype none

module tb_compute_cluster;

    // Same values as the DUT defaults
    localparam int unsigned NumCu = 2;
    localparam int unsigned NumWarpSlots = 4;
    localparam int unsigned Capacity = NumCu * (NumWarpSlots + 1) + 1;
    localparam int unsigned NumGroupIds = 2 ** cluster_cfg_pkg::TgroupIdBits;

    logic clk_i;
    logic rst_n_i;
    logic allocate_warp_i;
    tblock_pkg::alloc_t allocate_data_i;
    logic warp_free_o;
    logic tblock_done_ready_i;
    logic tblock_done_o;
    tblock_pkg::done_t tblock_done_data_o;

    // Scoreboard indexed by group id
    tblock_pkg::done_t exp_done [NumGroupIds];
    logic exp_vld [NumGroupIds];
    int outstanding;
    int received;
    tblock_pkg::done_t last_done;

    int value_errors;
    int other_errors;
    logic ready_random;

    // Output hold tracking for the stability check
    logic held_valid;
    tblock_pkg::done_t held_data;

    compute_cluster DUT (
        .clk_i               ( clk_i               ),
        .rst_n_i             ( rst_n_i             ),
        .allocate_warp_i     ( allocate_warp_i     ),
        .allocate_data_i     ( allocate_data_i     ),
        .warp_free_o         ( warp_free_o         ),
        .tblock_done_ready_i ( tblock_done_ready_i ),
        .tblock_done_o       ( tblock_done_o       ),
        .tblock_done_data_o  ( tblock_done_data_o  )
    );

    `include "tb_tasks.svh"

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Random ready, only while the random traffic test runs
    always @(posedge clk_i) begin
        #2;
        if (ready_random) begin
            tblock_done_ready_i = 1'($urandom_range(1, 0));
        end
    end

    // ##############################
    // Completion monitor, sampled mid cycle
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (held_valid) begin
                check_flag("tblock_done_o", tblock_done_o, 1'b1);
                check_done("tblock_done_data_o", tblock_done_data_o, held_data);
            end
            if (tblock_done_o && tblock_done_ready_i) begin
                record_completion(tblock_done_data_o);
            end
            held_valid = tblock_done_o && !tblock_done_ready_i;
            held_data  = tblock_done_data_o;
        end
    end

    initial begin
        int seed_value;
        seed_value = $urandom(36338);
        rst_n_i = 1'b0;
        allocate_warp_i = 1'b0;
        allocate_data_i = '0;
        tblock_done_ready_i = 1'b0;
        ready_random = 1'b0;
        held_valid = 1'b0;
        held_data = '0;
        last_done = '0;
        outstanding = 0;
        received = 0;
        value_errors = 0;
        other_errors = 0;
        for (int g = 0; g < NumGroupIds; g++) begin
            exp_vld[g] = 1'b0;
        end
        repeat (10) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;

        test_after_reset();
        test_single_block();
        test_backpressure();
        test_drain();
        test_random_traffic();

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+tb
rtl/cluster_cfg_pkg.sv
rtl/tblock_pkg.sv
rtl/tblock_dispatch.sv
rtl/compute_unit.sv
rtl/tblock_done_arbiter.sv
rtl/compute_cluster.sv
tb/tb_compute_cluster.sv

// File: Makefile
# Verilator build and run of the compute cluster testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_compute_cluster
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TB PASSED

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
